// ==== cache_axi_bridge.f ====
+incdir+include
logic/bridge_pkg.sv
logic/read_arbiter.sv
logic/write_burst.sv
logic/cache_axi_bridge.sv
tb/cache_axi_bridge_properties.sv
tb/cache_axi_bridge_tb.sv

// ==== include/bridge_defines.svh ====
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// line geometry, 16 words of 4 bytes
`define BRIDGE_LINE_WORDS 16
`define BRIDGE_LINE_OFS_W 6

// arlen / awlen
`define BRIDGE_LEN_LINE 15
`define BRIDGE_LEN_SINGLE 0

`define BRIDGE_BURST_INCR 1
`define BRIDGE_BURST_FIXED 0

// R beats are steered back to the cache by these ids
`define BRIDGE_ID_INST 0
`define BRIDGE_ID_DATA 1
`define BRIDGE_ID_W 4

`endif

// ==== logic/bridge_pkg.sv ====
`default_nettype none

`include "bridge_defines.svh"

package bridge_pkg;

	typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;
	typedef logic [`BRIDGE_DATA_W-1:0] word_t;
	typedef logic [`BRIDGE_LINE_WORDS*`BRIDGE_DATA_W-1:0] line_t; // word 0 in the low bits
	typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;
	typedef logic [3:0] axi_len_t;
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;
	typedef logic [1:0] axi_resp_t;
	typedef logic [`BRIDGE_ID_W-1:0] axi_id_t;
	typedef logic [3:0] beat_cnt_t;

	typedef enum logic [2:0] {
		rd_idle,
		rd_inst_send,
		rd_inst_wait,
		rd_data_send,
		rd_data_wait
	} rd_state_e;

	typedef enum logic [1:0] {
		wr_idle,
		wr_addr,
		wr_data,
		wr_resp
	} wr_state_e;

	// sram-like requests from the caches
	typedef struct packed {
		logic      req;
		logic      uncached;
		axi_size_t size;
		addr_t     addr;
	} rd_req_t;

	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} rd_ret_t;

	typedef struct packed {
		logic      req;
		logic      uncached;
		axi_size_t size;
		addr_t     addr;
		strb_t     strb;
		line_t     line;   // cached write payload
		word_t     word;   // uncached write payload
	} wr_req_t;

	typedef struct packed {
		logic  busy;
		addr_t addr;
	} wr_pending_t;

	// AXI3 channels, side-band fields left out
	typedef struct packed {
		logic       valid;
		axi_id_t    id;
		addr_t      addr;
		axi_len_t   len;
		axi_size_t  size;
		axi_burst_t burst;
	} ar_chan_t;

	typedef struct packed {
		logic       valid;
		addr_t      addr;
		axi_len_t   len;
		axi_size_t  size;
		axi_burst_t burst;
	} aw_chan_t;

	typedef struct packed {
		logic  valid;
		word_t data;
		strb_t strb;
		logic  last;
	} w_chan_t;

	typedef struct packed {
		logic      valid;
		axi_id_t   id;
		word_t     data;
		axi_resp_t resp;
		logic      last;
	} r_chan_t;

endpackage

`default_nettype wire

// ==== logic/cache_axi_bridge.sv ====
`default_nettype none

module cache_axi_bridge
(
	input  wire                        clk,
	input  wire                        rst,

	// cache read side
	input  wire bridge_pkg::rd_req_t   icache_rd,
	input  wire bridge_pkg::rd_req_t   dcache_rd,
	output logic                       icache_rd_rdy,
	output logic                       dcache_rd_rdy,
	output bridge_pkg::rd_ret_t        icache_ret,
	output bridge_pkg::rd_ret_t        dcache_ret,

	// dcache write side
	input  wire bridge_pkg::wr_req_t   dcache_wr,
	output logic                       dcache_wr_rdy,

	// AXI read
	output bridge_pkg::ar_chan_t       ar,
	input  wire                        arready,
	input  wire bridge_pkg::r_chan_t   r,
	output logic                       rready,

	// AXI write
	output bridge_pkg::aw_chan_t       aw,
	input  wire                        awready,
	output bridge_pkg::w_chan_t        w,
	input  wire                        wready,
	input  wire                        bvalid,
	input  wire bridge_pkg::axi_resp_t bresp,
	output logic                       bready
);

	// write in flight, seen by the read side for the line hazard
	bridge_pkg::wr_pending_t wr_pending;

	assign rready = 1'b1; // R beats always taken

	read_arbiter rd_i
	(
		.clk           (clk),
		.rst           (rst),
		.icache_rd     (icache_rd),
		.dcache_rd     (dcache_rd),
		.icache_rd_rdy (icache_rd_rdy),
		.dcache_rd_rdy (dcache_rd_rdy),
		.icache_ret    (icache_ret),
		.dcache_ret    (dcache_ret),
		.wr_pending    (wr_pending),
		.ar            (ar),
		.arready       (arready),
		.r             (r)
	);

	write_burst wr_i
	(
		.clk           (clk),
		.rst           (rst),
		.dcache_wr     (dcache_wr),
		.dcache_wr_rdy (dcache_wr_rdy),
		.wr_pending    (wr_pending),
		.aw            (aw),
		.awready       (awready),
		.w             (w),
		.wready        (wready),
		.bvalid        (bvalid),
		.bresp         (bresp),
		.bready        (bready)
	);

endmodule

`default_nettype wire

// ==== logic/read_arbiter.sv ====
`default_nettype none

`include "bridge_defines.svh"

module read_arbiter
(
	input  wire                           clk,
	input  wire                           rst,

	input  wire bridge_pkg::rd_req_t      icache_rd,
	input  wire bridge_pkg::rd_req_t      dcache_rd,
	output logic                          icache_rd_rdy,
	output logic                          dcache_rd_rdy,
	output bridge_pkg::rd_ret_t           icache_ret,
	output bridge_pkg::rd_ret_t           dcache_ret,

	input  wire bridge_pkg::wr_pending_t  wr_pending,

	output bridge_pkg::ar_chan_t          ar,
	input  wire                           arready,
	input  wire bridge_pkg::r_chan_t      r
);

	bridge_pkg::rd_state_e state_q;
	bridge_pkg::rd_state_e state_d;
	bridge_pkg::rd_req_t   sel;   // request driving AR
	logic                  inst_go;
	logic                  data_go;
	logic                  inst_done;
	logic                  data_done;
	logic                  inst_send;
	logic                  id_is_inst;
	logic                  id_is_data;

	// true when both addresses fall in the same cache line
	function automatic logic same_line(input bridge_pkg::addr_t a, input bridge_pkg::addr_t b);
		return a[`BRIDGE_ADDR_W-1:`BRIDGE_LINE_OFS_W] == b[`BRIDGE_ADDR_W-1:`BRIDGE_LINE_OFS_W];
	endfunction

	// hold back reads that hit the line of the write in flight
	assign inst_go = icache_rd.req &&
		!(wr_pending.busy && same_line(icache_rd.addr, wr_pending.addr));
	assign data_go = dcache_rd.req &&
		!(wr_pending.busy && same_line(dcache_rd.addr, wr_pending.addr));

	assign id_is_inst = r.id == bridge_pkg::axi_id_t'(`BRIDGE_ID_INST);
	assign id_is_data = r.id == bridge_pkg::axi_id_t'(`BRIDGE_ID_DATA);

	// last beat of the burst that belongs to each port
	assign inst_done = r.valid && r.last && id_is_inst;
	assign data_done = r.valid && r.last && id_is_data;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state_q <= bridge_pkg::rd_idle;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			bridge_pkg::rd_idle:
			begin
				if (inst_go) // icache wins a tie
					state_d = bridge_pkg::rd_inst_send;
				else if (data_go)
					state_d = bridge_pkg::rd_data_send;
			end
			bridge_pkg::rd_inst_send:
			begin
				if (arready)
					state_d = bridge_pkg::rd_inst_wait;
			end
			bridge_pkg::rd_inst_wait:
			begin
				if (inst_done)
					state_d = data_go ? bridge_pkg::rd_data_send : bridge_pkg::rd_idle;
			end
			bridge_pkg::rd_data_send:
			begin
				if (arready)
					state_d = bridge_pkg::rd_data_wait;
			end
			bridge_pkg::rd_data_wait:
			begin
				if (data_done)
					state_d = inst_go ? bridge_pkg::rd_inst_send : bridge_pkg::rd_idle;
			end
			default:
				state_d = bridge_pkg::rd_idle;
		endcase
	end

	assign inst_send = state_q == bridge_pkg::rd_inst_send;
	assign sel = inst_send ? icache_rd : dcache_rd;

	always_comb
	begin
		ar.valid = inst_send || (state_q == bridge_pkg::rd_data_send);
		ar.id    = inst_send ? bridge_pkg::axi_id_t'(`BRIDGE_ID_INST)
		                     : bridge_pkg::axi_id_t'(`BRIDGE_ID_DATA);
		ar.addr  = sel.addr;
		ar.size  = sel.size;
		// uncached gets one fixed beat, cached a full line
		ar.len   = sel.uncached ? bridge_pkg::axi_len_t'(`BRIDGE_LEN_SINGLE)
		                        : bridge_pkg::axi_len_t'(`BRIDGE_LEN_LINE);
		ar.burst = sel.uncached ? bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED)
		                        : bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);
	end

	// rdy doubles as the AR handshake for that port
	assign icache_rd_rdy = inst_send && arready;
	assign dcache_rd_rdy = (state_q == bridge_pkg::rd_data_send) && arready;

	// no back-pressure, beats go straight back by id
	always_comb
	begin
		icache_ret.valid = r.valid && id_is_inst;
		icache_ret.last  = r.last && id_is_inst;
		icache_ret.data  = r.data;
		dcache_ret.valid = r.valid && id_is_data;
		dcache_ret.last  = r.last && id_is_data;
		dcache_ret.data  = r.data;
	end

endmodule

`default_nettype wire

// ==== logic/write_burst.sv ====
`default_nettype none

`include "bridge_defines.svh"

module write_burst
(
	input  wire                        clk,
	input  wire                        rst,

	input  wire bridge_pkg::wr_req_t   dcache_wr,
	output logic                       dcache_wr_rdy,

	output bridge_pkg::wr_pending_t    wr_pending,

	output bridge_pkg::aw_chan_t       aw,
	input  wire                        awready,
	output bridge_pkg::w_chan_t        w,
	input  wire                        wready,
	input  wire                        bvalid,
	input  wire bridge_pkg::axi_resp_t bresp,  // response code is not checked
	output logic                       bready
);

	bridge_pkg::wr_state_e state_q;
	bridge_pkg::wr_state_e state_d;

	bridge_pkg::line_t     line_q;   // shifts down one word per beat
	bridge_pkg::word_t     word_q;
	bridge_pkg::addr_t     addr_q;
	bridge_pkg::strb_t     strb_q;
	bridge_pkg::axi_size_t size_q;
	logic                  uncached_q;
	bridge_pkg::beat_cnt_t beat_q;

	logic accept;
	logic aw_fire;
	logic w_fire;
	logic b_fire;

	assign dcache_wr_rdy = state_q == bridge_pkg::wr_idle;
	assign accept        = dcache_wr.req && dcache_wr_rdy;
	assign aw_fire       = aw.valid && awready;
	assign w_fire        = w.valid && wready;
	assign b_fire        = bvalid && bready;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state_q <= bridge_pkg::wr_idle;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			bridge_pkg::wr_idle:
				if (accept)
					state_d = bridge_pkg::wr_addr;
			bridge_pkg::wr_addr:
				if (aw_fire)
					state_d = bridge_pkg::wr_data;
			bridge_pkg::wr_data:
				if (w_fire && w.last)
					state_d = bridge_pkg::wr_resp;
			bridge_pkg::wr_resp:
				if (b_fire)
					state_d = bridge_pkg::wr_idle;
			default:
				state_d = bridge_pkg::wr_idle;
		endcase
	end

	// request payload, captured once at acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			line_q     <= dcache_wr.line;
			word_q     <= dcache_wr.word;
			addr_q     <= dcache_wr.addr;
			strb_q     <= dcache_wr.strb;
			size_q     <= dcache_wr.size;
			uncached_q <= dcache_wr.uncached;
		end
		else if (w_fire)
			line_q <= line_q >> `BRIDGE_DATA_W;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			beat_q <= '0;
		else if (accept)
			beat_q <= '0;
		else if (w_fire)
			beat_q <= beat_q + 1'b1;
	end

	// busy from the accept cycle on, so a read issued in that same cycle is held too
	always_comb
	begin
		wr_pending.busy = accept || (state_q != bridge_pkg::wr_idle);
		wr_pending.addr = accept ? dcache_wr.addr : addr_q;
	end

	always_comb
	begin
		aw.valid = state_q == bridge_pkg::wr_addr;
		aw.addr  = addr_q;
		aw.size  = size_q;
		aw.len   = uncached_q ? bridge_pkg::axi_len_t'(`BRIDGE_LEN_SINGLE)
		                      : bridge_pkg::axi_len_t'(`BRIDGE_LEN_LINE);
		aw.burst = uncached_q ? bridge_pkg::axi_burst_t'(`BRIDGE_BURST_FIXED)
		                      : bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR);
	end

	always_comb
	begin
		w.valid = state_q == bridge_pkg::wr_data;
		w.data  = uncached_q ? word_q : line_q[`BRIDGE_DATA_W-1:0];
		w.strb  = strb_q;
		// single word, or beat 15 of a line
		w.last  = uncached_q ||
			(beat_q == bridge_pkg::beat_cnt_t'(`BRIDGE_LINE_WORDS - 1));
	end

	assign bready = state_q == bridge_pkg::wr_resp;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cache_axi_bridge.f \
	--top-module cache_axi_bridge_tb -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "FAIL: build or simulation stopped"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "FAIL: no result line in sim.log"; exit 1; }
echo "PASS"

// ==== tb/cache_axi_bridge_properties.sv ====
`default_nettype none

`include "bridge_defines.svh"

module cache_axi_bridge_properties
(
	input wire                          clk,
	input wire                          rst,
	input wire bridge_pkg::rd_req_t     icache_rd,
	input wire bridge_pkg::rd_req_t     dcache_rd,
	input wire                          icache_rd_rdy,
	input wire                          dcache_rd_rdy,
	input wire bridge_pkg::wr_pending_t wr_pending,
	input wire bridge_pkg::ar_chan_t    ar,
	input wire                          arready,
	input wire bridge_pkg::aw_chan_t    aw,
	input wire                          awready,
	input wire bridge_pkg::w_chan_t     w,
	input wire                          wready
);
	timeunit 1ns;
	timeprecision 100ps;

	bridge_pkg::beat_cnt_t beats;   // W handshakes since the AW handshake
	bridge_pkg::axi_len_t  len_q;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			beats <= '0;
			len_q <= '0;
		end
		else if (aw.valid && awready)
		begin
			beats <= '0;
			len_q <= aw.len;
		end
		else if (w.valid && wready)
			beats <= beats + 4'd1;
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rst)
		ar.valid && !arready |=> ar.valid && $stable(ar))
		else $error("AR valid dropped or fields changed before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rst)
		aw.valid && !awready |=> aw.valid && $stable(aw))
		else $error("AW valid dropped or fields changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!rst)
		w.valid && !wready |=> w.valid && $stable(w))
		else $error("W valid dropped or fields changed before wready");

	// wlast on the final beat only
	w_last: assert property (@(posedge clk) disable iff (!rst)
		w.valid |-> (w.last == (beats == len_q)))
		else $error("wlast does not match the beat count");

	ar_hazard: assert property (@(posedge clk) disable iff (!rst)
		ar.valid && wr_pending.busy |->
		ar.addr[`BRIDGE_ADDR_W-1:`BRIDGE_LINE_OFS_W] !=
		wr_pending.addr[`BRIDGE_ADDR_W-1:`BRIDGE_LINE_OFS_W])
		else $error("AR issued into the line of a pending write");

	irdy_req: assert property (@(posedge clk) disable iff (!rst)
		icache_rd_rdy |-> icache_rd.req)
		else $error("icache rdy without a request");

	drdy_req: assert property (@(posedge clk) disable iff (!rst)
		dcache_rd_rdy |-> dcache_rd.req)
		else $error("dcache rdy without a request");

endmodule

bind cache_axi_bridge cache_axi_bridge_properties props_i
(
	.clk           (clk),
	.rst           (rst),
	.icache_rd     (icache_rd),
	.dcache_rd     (dcache_rd),
	.icache_rd_rdy (icache_rd_rdy),
	.dcache_rd_rdy (dcache_rd_rdy),
	.wr_pending    (wr_pending),
	.ar            (ar),
	.arready       (arready),
	.aw            (aw),
	.awready       (awready),
	.w             (w),
	.wready        (wready)
);

`default_nettype wire

// ==== tb/cache_axi_bridge_tb.sv ====
`default_nettype none

`include "bridge_defines.svh"

module cache_axi_bridge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cycles_per_test = 400;
	localparam int max_cycles = 6 * cycles_per_test + 600;

	logic clk;
	logic rst;
	bridge_pkg::rd_req_t     icache_rd;
	bridge_pkg::rd_req_t     dcache_rd;
	logic                    icache_rd_rdy;
	logic                    dcache_rd_rdy;
	bridge_pkg::rd_ret_t     icache_ret;
	bridge_pkg::rd_ret_t     dcache_ret;
	bridge_pkg::wr_req_t     dcache_wr;
	logic                    dcache_wr_rdy;
	bridge_pkg::ar_chan_t    ar;
	logic                    arready;
	bridge_pkg::r_chan_t     r;
	logic                    rready;
	bridge_pkg::aw_chan_t    aw;
	logic                    awready;
	bridge_pkg::w_chan_t     w;
	logic                    wready;
	logic                    bvalid;
	bridge_pkg::axi_resp_t   bresp;
	logic                    bready;

	bridge_pkg::word_t mem [0:1023];        // slave memory written by W beats
	bridge_pkg::word_t expect_mem [0:1023]; // what the tb wrote
	logic [31:0] lfsr = 32'h4870_e155;
	int unsigned cycle = 0;
	int unsigned errors = 0;
	int unsigned passed = 0;
	int unsigned failed = 0;
	int unsigned ar_cycle;
	int unsigned b_cycle;
	bridge_pkg::ar_chan_t last_ar;
	bridge_pkg::aw_chan_t last_aw;
	bridge_pkg::axi_id_t  ar_ids[$];
	bridge_pkg::w_chan_t  w_log[$];
	bridge_pkg::word_t    inst_got[$];
	bridge_pkg::word_t    data_got[$];
	logic                 inst_lasts[$];
	logic                 data_lasts[$];

	cache_axi_bridge dut_i
	(
		.clk           (clk),
		.rst           (rst),
		.icache_rd     (icache_rd),
		.dcache_rd     (dcache_rd),
		.icache_rd_rdy (icache_rd_rdy),
		.dcache_rd_rdy (dcache_rd_rdy),
		.icache_ret    (icache_ret),
		.dcache_ret    (dcache_ret),
		.dcache_wr     (dcache_wr),
		.dcache_wr_rdy (dcache_wr_rdy),
		.ar            (ar),
		.arready       (arready),
		.r             (r),
		.rready        (rready),
		.aw            (aw),
		.awready       (awready),
		.w             (w),
		.wready        (wready),
		.bvalid        (bvalid),
		.bresp         (bresp),
		.bready        (bready)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	// taps 32 22 2 1
	function automatic logic step_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], step_bit()};
		return v;
	endfunction

	// memory content rule for words never written
	function automatic bridge_pkg::word_t rule_word(input bridge_pkg::addr_t a);
		return a ^ 32'hA5A5_0000;
	endfunction

	task automatic wait_cycles(input logic [31:0] n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	initial
	begin : read_slave
		bridge_pkg::ar_chan_t req;
		bridge_pkg::addr_t a;
		wait (rst);
		forever
		begin
			@(posedge clk);
			#1;
			if (ar.valid)
			begin
				wait_cycles(rand_bits(2));
				req = ar;
				arready = 1'b1;
				@(posedge clk);
				ar_cycle = cycle;
				last_ar = req;
				ar_ids.push_back(req.id);
				#1;
				arready = 1'b0;
				wait_cycles(rand_bits(2));
				for (int k = 0; k <= int'(req.len); k++)
				begin
					if (step_bit())
					begin
						r.valid = 1'b0; // one idle cycle between beats
						@(posedge clk);
						#1;
					end
					a = (req.burst == bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR)) ?
						req.addr + 32'(4 * k) : req.addr;
					r.valid = 1'b1;
					r.id    = req.id;
					r.data  = mem[a[11:2]];
					r.resp  = '0;
					r.last  = (k == int'(req.len));
					check_that(rready, "rready was low while an R beat was offered");
					@(posedge clk);
					#1;
				end
				r = '0;
			end
		end
	end

	initial
	begin : write_slave
		bridge_pkg::aw_chan_t req;
		bridge_pkg::w_chan_t beat;
		bridge_pkg::addr_t a;
		int k;
		logic done;
		wait (rst);
		forever
		begin
			@(posedge clk);
			#1;
			if (aw.valid)
			begin
				wait_cycles(rand_bits(2));
				req = aw;
				last_aw = req;
				awready = 1'b1;
				@(posedge clk);
				#1;
				awready = 1'b0;
				k = 0;
				done = 1'b0;
				while (!done)
				begin
					wready = step_bit();
					beat = w; // fields stay put until the handshake edge
					@(posedge clk);
					#1;
					if (wready)
					begin
						wready = 1'b0;
						a = (req.burst == bridge_pkg::axi_burst_t'(`BRIDGE_BURST_INCR)) ?
							req.addr + 32'(4 * k) : req.addr;
						mem[a[11:2]] = beat.data;
						w_log.push_back(beat);
						k++;
						done = beat.last;
					end
				end
				wait_cycles(rand_bits(2));
				bvalid = 1'b1;
				check_that(bready, "bready was low while the write response was offered");
				@(posedge clk);
				b_cycle = cycle;
				#1;
				bvalid = 1'b0;
			end
		end
	end

	task automatic cache_read(input logic is_data, input logic uncached,
		input bridge_pkg::addr_t addr);
		bridge_pkg::rd_req_t rq;
		bridge_pkg::rd_ret_t ret;
		logic rdy;
		rq.req      = 1'b1;
		rq.uncached = uncached;
		rq.size     = 3'd2;
		rq.addr     = addr;
		@(posedge clk);
		#1;
		if (is_data)
		begin
			dcache_rd = rq;
			data_got.delete();
			data_lasts.delete();
		end
		else
		begin
			icache_rd = rq;
			inst_got.delete();
			inst_lasts.delete();
		end
		do
		begin
			@(negedge clk);
			rdy = is_data ? dcache_rd_rdy : icache_rd_rdy;
		end while (!rdy);
		@(posedge clk);
		#1;
		if (is_data)
			dcache_rd = '0;
		else
			icache_rd = '0;
		do
		begin
			@(negedge clk);
			ret = is_data ? dcache_ret : icache_ret;
			if (ret.valid && is_data)
			begin
				data_got.push_back(ret.data);
				data_lasts.push_back(ret.last);
			end
			else if (ret.valid)
			begin
				inst_got.push_back(ret.data);
				inst_lasts.push_back(ret.last);
			end
		end while (!(ret.valid && ret.last));
	endtask

	// returns once the bridge has taken the request
	task automatic cache_write(input logic uncached, input bridge_pkg::addr_t addr,
		input bridge_pkg::line_t line, input bridge_pkg::word_t word);
		bridge_pkg::wr_req_t wq;
		wq.req      = 1'b1;
		wq.uncached = uncached;
		wq.size     = 3'd2;
		wq.addr     = addr;
		wq.strb     = 4'hf;
		wq.line     = line;
		wq.word     = word;
		@(posedge clk);
		#1;
		dcache_wr = wq;
		w_log.delete();
		do
			@(negedge clk);
		while (!dcache_wr_rdy);
		@(posedge clk);
		#1;
		dcache_wr = '0;
	endtask

	task automatic check_word(input bridge_pkg::word_t got, input bridge_pkg::word_t exp,
		input string what);
		assert (got == exp)
		else
		begin
			errors++;
			$display("error %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_that(input logic ok, input string what);
		assert (ok)
		else
		begin
			errors++;
			$display("error %0t: %s", $time, what);
		end
	endtask

	// compare a finished burst with the tb's own memory image
	task automatic check_burst(input logic is_data, input bridge_pkg::addr_t base,
		input int n, input string what);
		bridge_pkg::word_t got[$];
		logic lasts[$];
		bridge_pkg::addr_t a;
		got   = is_data ? data_got : inst_got;
		lasts = is_data ? data_lasts : inst_lasts;
		check_that(got.size() == n, {what, " returned the wrong number of beats"});
		for (int k = 0; k < got.size() && k < n; k++)
		begin
			a = base + 32'(4 * k);
			check_word(got[k], expect_mem[a[11:2]], what);
			check_that(lasts[k] == (k == n - 1), {what, " has last on the wrong beat"});
		end
	endtask

	task automatic end_test(input string name, input int unsigned errors_before);
		if (errors == errors_before)
			passed++;
		else
			failed++;
		$display("test %s: %s", name, (errors == errors_before) ? "pass" : "fail");
	endtask

	initial
	begin : watchdog
		wait (cycle >= max_cycles);
		$display("timeout: the run did not finish within %0d clock cycles", max_cycles);
		$display("Errors found");
		$finish;
	end

	initial
	begin : main
		bridge_pkg::line_t line;
		bridge_pkg::word_t word;
		int unsigned e0;
		rst = 1'b0;
		icache_rd = '0;
		dcache_rd = '0;
		dcache_wr = '0;
		arready = 1'b0;
		r = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = '0;
		for (int i = 0; i < 1024; i++)
		begin
			mem[i] = rule_word(bridge_pkg::addr_t'(i * 4));
			expect_mem[i] = mem[i];
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		wait_cycles(2);

		e0 = errors;
		cache_read(1'b0, 1'b0, 32'h0000_0100);
		check_that(last_ar.id == 0 && last_ar.len == 15 && last_ar.burst == 1 &&
			last_ar.size == 2, "icache line read has wrong AR id, len, burst or size");
		check_burst(1'b0, 32'h0000_0100, 16, "icache line read");
		end_test("1 icache line read", e0);

		e0 = errors;
		cache_read(1'b1, 1'b1, 32'h0000_0204);
		check_that(last_ar.id == 1 && last_ar.len == 0 && last_ar.burst == 0,
			"uncached dcache read has wrong AR id, len or burst");
		check_burst(1'b1, 32'h0000_0204, 1, "uncached dcache read");
		end_test("2 uncached dcache read", e0);

		e0 = errors;
		ar_ids.delete();
		fork
			cache_read(1'b0, 1'b0, 32'h0000_0300);
			cache_read(1'b1, 1'b0, 32'h0000_0340);
		join
		check_that(ar_ids.size() == 2 && ar_ids[0] == 0 && ar_ids[1] == 1,
			"simultaneous reads were not served icache first");
		check_burst(1'b0, 32'h0000_0300, 16, "icache read in tie");
		check_burst(1'b1, 32'h0000_0340, 16, "dcache read in tie");
		end_test("3 arbitration tie", e0);

		e0 = errors;
		for (int k = 0; k < 16; k++)
		begin
			line[k*32 +: 32] = rand_bits(32);
			expect_mem[256 + k] = line[k*32 +: 32]; // line at 0x400
		end
		cache_write(1'b0, 32'h0000_0400, line, '0);
		cache_read(1'b1, 1'b0, 32'h0000_0400);
		check_that(w_log.size() == 16 && last_aw.len == 15 && last_aw.size == 2,
			"line write beat count, awlen or awsize wrong");
		for (int k = 0; k < w_log.size() && k < 16; k++)
		begin
			check_word(w_log[k].data, line[k*32 +: 32], "line write W beat");
			check_that(w_log[k].last == (k == 15), "line write wlast on the wrong beat");
			check_that(w_log[k].strb == 4'hf, "line write W beat has the wrong strobes");
		end
		check_burst(1'b1, 32'h0000_0400, 16, "line readback");
		end_test("4 cached line write", e0);

		e0 = errors;
		word = rand_bits(32);
		expect_mem[32'h508 >> 2] = word;
		cache_write(1'b1, 32'h0000_0508, '0, word);
		cache_read(1'b1, 1'b1, 32'h0000_0508);
		check_that(w_log.size() == 1 && last_aw.len == 0, "uncached write is not one beat");
		if (w_log.size() > 0)
		begin
			check_word(w_log[0].data, word, "uncached write W beat");
			check_that(w_log[0].last, "uncached write beat has no wlast");
			check_that(w_log[0].strb == 4'hf, "uncached write beat has the wrong strobes");
		end
		check_burst(1'b1, 32'h0000_0508, 1, "uncached readback");
		end_test("5 uncached write", e0);

		e0 = errors;
		for (int k = 0; k < 16; k++)
		begin
			line[k*32 +: 32] = rand_bits(32);
			expect_mem[384 + k] = line[k*32 +: 32]; // line at 0x600
		end
		b_cycle = '1; // no B seen for this write yet
		fork
			cache_write(1'b0, 32'h0000_0600, line, '0);
			begin
				@(posedge clk);
				cache_read(1'b1, 1'b0, 32'h0000_0600);
			end
			begin
				@(posedge clk);
				cache_read(1'b0, 1'b0, 32'h0000_0000); // other line goes ahead
			end
		join
		check_that(ar_cycle > b_cycle, "read AR was issued before the write response");
		check_burst(1'b0, 32'h0000_0000, 16, "icache read during write");
		check_burst(1'b1, 32'h0000_0600, 16, "read after write hazard");
		end_test("6 write hazard hold", e0);

		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
